// ==== board_pkg.sv ====
package board_pkg;

  localparam int ADDR_WIDTH = 10;

  typedef logic [ADDR_WIDTH-1:0] addr_t;  // byte address
  typedef logic [15:0] word_t;
  typedef logic [7:0] byte_t;

  localparam addr_t LOAD_BASE = 10'h200;  // program load starts here

  // memory-mapped registers
  localparam addr_t IO_LEDLCD = 10'h080;
  localparam addr_t IO_LCD = 10'h081;
  localparam addr_t IO_UART = 10'h082;
  localparam addr_t IO_BASE_MASK = 10'h3e0;  // 0x080..0x09f is all I/O

  typedef struct packed {
    addr_t addr;
    logic  wr;
    logic  byt;      // byte access, data in the low byte
    word_t wr_data;
  } mem_req_t;

  typedef struct packed {
    word_t       stack0;
    word_t       stack1;
    logic [5:0]  alu_sel;
  } cpu_view_t;

  typedef struct packed {
    logic       e;
    logic       rw;
    logic       rs;
    logic [3:0] db;
  } lcd_pins_t;

endpackage

// ==== uart.sv ====
`timescale 1ns/1ps

module uart #(
  parameter int CLKS_PER_BIT = 234
) (
  input  logic             sys_clk,
  input  logic             rst_n,
  input  logic             rx,
  output logic             tx,
  output board_pkg::byte_t rx_data,
  output logic             rx_valid,
  input  board_pkg::byte_t tx_data,
  input  logic             tx_start
);

  localparam int CW = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CW-1:0] BIT_LAST = CW'(CLKS_PER_BIT - 1);
  localparam logic [CW-1:0] HALF_LAST = CW'(CLKS_PER_BIT / 2 - 1);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t        rx_state;
  logic [1:0]       rx_sync;
  logic [CW-1:0]    rx_cnt;
  logic [2:0]       rx_bit;
  board_pkg::byte_t rx_shift;

  logic             tx_busy;
  logic [9:0]       tx_frame;  // stop, data, start
  logic [3:0]       tx_bit;
  logic [CW-1:0]    tx_cnt;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync <= 2'b11;  // line idles high
    end else begin
      rx_sync <= {rx_sync[0], rx};
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_state <= RX_IDLE;
      rx_cnt   <= '0;
      rx_bit   <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (rx_state)
        RX_IDLE: begin
          rx_cnt <= '0;
          if (!rx_sync[1]) rx_state <= RX_START;
        end
        RX_START: begin
          if (rx_cnt == HALF_LAST) begin  // middle of start bit
            rx_cnt   <= '0;
            rx_bit   <= '0;
            rx_state <= rx_sync[1] ? RX_IDLE : RX_DATA;  // glitch, back to idle
          end else begin
            rx_cnt <= rx_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (rx_cnt == BIT_LAST) begin
            rx_cnt <= '0;
            rx_bit <= rx_bit + 1'b1;
            if (rx_bit == 3'd7) rx_state <= RX_STOP;
          end else begin
            rx_cnt <= rx_cnt + 1'b1;
          end
        end
        default: begin  // stop bit
          if (rx_cnt == BIT_LAST) begin
            rx_valid <= rx_sync[1];  // framing error drops the byte
            rx_state <= RX_IDLE;
          end else begin
            rx_cnt <= rx_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // lsb first, so shift in from the top
  always_ff @(posedge sys_clk) begin
    if (rx_state == RX_DATA && rx_cnt == BIT_LAST) rx_shift <= {rx_sync[1], rx_shift[7:1]};
  end

  assign rx_data = rx_shift;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_busy  <= 1'b0;
      tx_frame <= '1;
      tx_bit   <= '0;
      tx_cnt   <= '0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        tx_busy  <= 1'b1;
        tx_frame <= {1'b1, tx_data, 1'b0};
        tx_bit   <= '0;
        tx_cnt   <= '0;
      end
    end else if (tx_cnt == BIT_LAST) begin
      tx_cnt   <= '0;
      tx_frame <= {1'b1, tx_frame[9:1]};  // refill with idle level
      tx_bit   <= tx_bit + 1'b1;
      if (tx_bit == 4'd9) tx_busy <= 1'b0;
    end else begin
      tx_cnt <= tx_cnt + 1'b1;
    end
  end

  assign tx = tx_frame[0];

endmodule

// ==== program_loader.sv ====
`timescale 1ns/1ps

module program_loader (
  input  logic                 sys_clk,
  input  logic                 rst_n,
  input  board_pkg::byte_t     rx_data,
  input  logic                 rx_valid,
  input  board_pkg::mem_req_t  cpu_req,
  output board_pkg::mem_req_t  mem_req,
  output board_pkg::word_t     rx_word,
  output logic                 rx_word_valid,
  output logic                 cpu_run
);

  logic             phase;     // 0 waits for high byte, 1 for low byte
  board_pkg::word_t pair;      // last two bytes, first one on top
  logic             word_stb;
  board_pkg::addr_t load_addr;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      phase    <= 1'b0;
      pair     <= '0;
      word_stb <= 1'b0;
    end else begin
      word_stb <= rx_valid & phase;
      if (rx_valid) begin
        phase <= ~phase;
        pair  <= {pair[7:0], rx_data};
      end
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      load_addr <= board_pkg::LOAD_BASE;
      cpu_run   <= 1'b0;
    end else begin
      if (cpu_run)
        load_addr <= board_pkg::LOAD_BASE;  // next load starts over
      else if (word_stb)
        load_addr <= load_addr + board_pkg::addr_t'(2);

      if (word_stb && pair == 16'hffff)
        cpu_run <= 1'b1;
      else if (rx_valid && !phase && rx_data[7:1] != 7'h7f)
        cpu_run <= 1'b0;  // a new program is coming in
    end
  end

  always_comb begin
    if (cpu_run) begin
      mem_req = cpu_req;
    end else begin
      mem_req.addr    = load_addr;
      mem_req.wr      = word_stb;
      mem_req.byt     = 1'b0;
      mem_req.wr_data = pair;
    end
  end

  assign rx_word       = pair;
  assign rx_word_valid = word_stb;

endmodule

// ==== byte_mem.sv ====
`timescale 1ns/1ps

module byte_mem (
  input  logic                sys_clk,
  input  logic                rst_n,
  input  board_pkg::mem_req_t mem_req,
  output board_pkg::word_t    rd_data
);

  localparam int IW = board_pkg::ADDR_WIDTH - 1;
  localparam int DEPTH = 2 ** IW;

  logic [IW-1:0] idx;

  assign idx = mem_req.addr[board_pkg::ADDR_WIDTH-1:1];  // word index, bit 0 picks bank

  // bank 0 holds even addresses, bank 1 odd ones
  for (genvar b = 0; b < 2; b++) begin : g_bank
    board_pkg::byte_t ram [DEPTH];
    board_pkg::byte_t din;
    board_pkg::byte_t dout;
    logic             we;

    assign we = mem_req.wr && (!mem_req.byt || mem_req.addr[0] == (b == 1));

    // byte writes carry their data in the low byte
    assign din = (b == 0 || mem_req.byt) ? mem_req.wr_data[7:0] : mem_req.wr_data[15:8];

    always_ff @(posedge sys_clk) begin
      if (we) ram[idx] <= din;
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
        dout <= '0;
      end else begin
        dout <= ram[idx];  // old data on a same-cycle write
      end
    end
  end

  assign rd_data = {g_bank[1].dout, g_bank[0].dout};

endmodule

// ==== io_regs.sv ====
`timescale 1ns/1ps

module io_regs (
  input  logic                 sys_clk,
  input  logic                 rst_n,
  input  board_pkg::mem_req_t  cpu_req,
  input  board_pkg::word_t     mem_rd_data,
  input  board_pkg::word_t     rx_word,
  input  logic                 rx_word_valid,
  output board_pkg::word_t     cpu_rd_data,
  output board_pkg::byte_t     io_led,
  output board_pkg::lcd_pins_t lcd,
  output board_pkg::byte_t     tx_data,
  output logic                 tx_start
);

  localparam int AW = board_pkg::ADDR_WIDTH;

  board_pkg::byte_t lcd_reg;    // e rw rs - db[3:0]
  board_pkg::word_t rx_word_q;
  board_pkg::addr_t addr_d;     // lines up with the memory read
  logic             wr_ledlcd;
  logic             wr_lcd;
  logic             wr_uart;

  assign wr_ledlcd = cpu_req.wr && cpu_req.addr == board_pkg::IO_LEDLCD;
  assign wr_lcd    = cpu_req.wr && cpu_req.addr == board_pkg::IO_LCD;
  assign wr_uart   = cpu_req.wr && cpu_req.addr == board_pkg::IO_UART;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      io_led    <= '0;
      lcd_reg   <= '0;
      tx_data   <= '0;
      tx_start  <= 1'b0;
      rx_word_q <= '0;
      addr_d    <= '0;
    end else begin
      addr_d   <= cpu_req.addr;
      tx_start <= wr_uart;
      if (wr_ledlcd) begin
        io_led <= cpu_req.wr_data[7:0];
        if (!cpu_req.byt) lcd_reg <= cpu_req.wr_data[15:8];  // word write sets both
      end else if (wr_lcd) begin
        lcd_reg <= cpu_req.wr_data[15:8];
      end
      if (wr_uart) tx_data <= cpu_req.wr_data[7:0];
      if (rx_word_valid) rx_word_q <= rx_word;
    end
  end

  assign lcd.e  = lcd_reg[0];
  assign lcd.rw = lcd_reg[1];
  assign lcd.rs = lcd_reg[2];
  assign lcd.db = lcd_reg[7:4];

  always_comb begin
    if ((addr_d & board_pkg::IO_BASE_MASK) == board_pkg::IO_LEDLCD) begin
      if (addr_d[AW-1:1] == board_pkg::IO_LEDLCD[AW-1:1])
        cpu_rd_data = {lcd_reg, io_led};
      else if (addr_d[AW-1:1] == board_pkg::IO_UART[AW-1:1])
        cpu_rd_data = rx_word_q;
      else
        cpu_rd_data = '0;  // unused I/O slot
    end else begin
      cpu_rd_data = mem_rd_data;
    end
  end

endmodule

// ==== led_matrix_scan.sv ====
`timescale 1ns/1ps

module led_matrix_scan #(
  parameter int SCAN_PERIOD = 27000,
  parameter int GAP_ON      = 100,
  parameter int GAP_OFF     = 2000
) (
  input  logic                 sys_clk,
  input  logic                 rst_n,
  input  board_pkg::mem_req_t  mem_req,
  input  board_pkg::cpu_view_t cpu_view,
  input  board_pkg::byte_t     io_led,
  output logic [7:0]           led_col,
  output logic [8:0]           led_row
);

  localparam int CW = $clog2(SCAN_PERIOD);
  localparam logic [CW-1:0] CNT_LAST = CW'(SCAN_PERIOD - 1);
  localparam logic [CW-1:0] LIT_FROM = CW'(GAP_ON);
  localparam logic [CW-1:0] LIT_UNTIL = CW'(SCAN_PERIOD - GAP_OFF);

  logic [CW-1:0] cnt;
  logic [3:0]    row;
  logic          lit;

  // segments a..g then dot, a on the msb
  function automatic logic [7:0] seg7(input logic [4:0] n);
    case (n[3:0])
      4'h0: seg7 = {7'b1111110, n[4]};
      4'h1: seg7 = {7'b0110000, n[4]};
      4'h2: seg7 = {7'b1101101, n[4]};
      4'h3: seg7 = {7'b1111001, n[4]};
      4'h4: seg7 = {7'b0110011, n[4]};
      4'h5: seg7 = {7'b1011011, n[4]};
      4'h6: seg7 = {7'b1011111, n[4]};
      4'h7: seg7 = {7'b1110000, n[4]};
      4'h8: seg7 = {7'b1111111, n[4]};
      4'h9: seg7 = {7'b1111011, n[4]};
      4'ha: seg7 = {7'b1110111, n[4]};
      4'hb: seg7 = {7'b0011111, n[4]};
      4'hc: seg7 = {7'b1001110, n[4]};
      4'hd: seg7 = {7'b0111101, n[4]};
      4'he: seg7 = {7'b1001111, n[4]};
      default: seg7 = {7'b1000111, n[4]};
    endcase
  endfunction

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
      row <= '0;
    end else if (cnt == CNT_LAST) begin
      cnt <= '0;
      row <= (row == 4'd8) ? 4'd0 : row + 4'd1;  // nine rows
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // dark gap around each row change avoids ghosting
  assign lit     = (cnt >= LIT_FROM) && (cnt < LIT_UNTIL);
  assign led_row = lit ? ~(9'd1 << row) : '1;

  always_comb begin
    case (row)
      4'd0:    led_col = mem_req.wr_data[15:8];
      4'd1:    led_col = mem_req.wr_data[7:0];
      4'd2:    led_col = cpu_view.stack0[15:8];
      4'd3:    led_col = cpu_view.stack0[7:0];
      4'd4:    led_col = cpu_view.stack1[15:8];
      4'd5:    led_col = cpu_view.stack1[7:0];
      4'd6:    led_col = {2'b00, cpu_view.alu_sel};
      4'd7:    led_col = io_led;
      default: led_col = seg7(mem_req.addr[4:0]);
    endcase
  end

endmodule

// ==== board_top.sv ====
`timescale 1ns/1ps

module board_top #(
  parameter int CLKS_PER_BIT = 234,   // 27 MHz at 115200 baud
  parameter int SCAN_PERIOD  = 27000,  // 1 ms per row
  parameter int GAP_ON       = 100,
  parameter int GAP_OFF      = 2000
) (
  input  logic                 sys_clk,
  input  logic                 rst_n,
  input  logic                 uart_rx,
  output logic                 uart_tx,
  input  board_pkg::mem_req_t  cpu_req,
  input  board_pkg::cpu_view_t cpu_view,
  output board_pkg::word_t     cpu_rd_data,
  output logic                 cpu_run,
  output logic [7:0]           led_col,
  output logic [8:0]           led_row,
  output board_pkg::lcd_pins_t lcd
);

  board_pkg::byte_t    rx_data;
  logic                rx_valid;
  board_pkg::byte_t    tx_data;
  logic                tx_start;
  board_pkg::mem_req_t mem_req;     // loader or cpu, whoever owns memory
  board_pkg::word_t    mem_rd_data;
  board_pkg::word_t    rx_word;
  logic                rx_word_valid;
  board_pkg::byte_t    io_led;

  uart #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart (
    .sys_clk(sys_clk), .rst_n(rst_n), .rx(uart_rx), .tx(uart_tx),
    .rx_data(rx_data), .rx_valid(rx_valid), .tx_data(tx_data), .tx_start(tx_start)
  );

  program_loader u_loader (
    .sys_clk(sys_clk), .rst_n(rst_n), .rx_data(rx_data), .rx_valid(rx_valid),
    .cpu_req(cpu_req), .mem_req(mem_req), .rx_word(rx_word),
    .rx_word_valid(rx_word_valid), .cpu_run(cpu_run)
  );

  byte_mem u_mem (
    .sys_clk(sys_clk), .rst_n(rst_n), .mem_req(mem_req), .rd_data(mem_rd_data)
  );

  io_regs u_io (
    .sys_clk(sys_clk), .rst_n(rst_n), .cpu_req(cpu_req), .mem_rd_data(mem_rd_data),
    .rx_word(rx_word), .rx_word_valid(rx_word_valid), .cpu_rd_data(cpu_rd_data),
    .io_led(io_led), .lcd(lcd), .tx_data(tx_data), .tx_start(tx_start)
  );

  led_matrix_scan #(
    .SCAN_PERIOD(SCAN_PERIOD), .GAP_ON(GAP_ON), .GAP_OFF(GAP_OFF)
  ) u_scan (
    .sys_clk(sys_clk), .rst_n(rst_n), .mem_req(mem_req), .cpu_view(cpu_view),
    .io_led(io_led), .led_col(led_col), .led_row(led_row)
  );

endmodule

// ==== board_chk.sv ====
`timescale 1ns/1ps

module board_chk (
  input logic                sys_clk,
  input logic                rst_n,
  input logic                rx_valid,
  input board_pkg::byte_t    rx_data,
  input board_pkg::mem_req_t mem_req,
  input logic                cpu_run,
  input logic                tx_start,
  input logic                uart_tx,
  input logic [8:0]          led_row
);

  int               fail_count = 0;
  logic             second_byte;  // next received byte completes a pair
  logic             tx_seen;
  board_pkg::byte_t last_byte;
  logic             end_word;     // an ff ff pair just completed

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      second_byte <= 1'b0;
      tx_seen     <= 1'b0;
      last_byte   <= '0;
      end_word    <= 1'b0;
    end else begin
      if (rx_valid) begin
        second_byte <= ~second_byte;
        last_byte   <= rx_data;
      end
      if (tx_start) tx_seen <= 1'b1;
      end_word <= rx_valid && second_byte && rx_data == 8'hff && last_byte == 8'hff;
    end
  end

  // while halted only the loader writes, right after a pair completes
  load_write_only: assert property (@(posedge sys_clk) disable iff (!rst_n)
    mem_req.wr && !cpu_run |-> $past(rx_valid && second_byte))
    else begin
      $error("memory write while halted without a completed byte pair");
      fail_count++;
    end

  // one row at a time, and never straight from one lit row to another
  one_row_lit: assert property (@(posedge sys_clk) disable iff (!rst_n)
    $countones(~led_row) <= 1 &&
    (led_row == '1 || $past(led_row) == '1 || led_row == $past(led_row)))
    else begin
      $error("more than one matrix row lit, or rows changed without a dark gap");
      fail_count++;
    end

  tx_idle: assert property (@(posedge sys_clk) disable iff (!rst_n)
    !tx_seen |-> uart_tx)
    else begin
      $error("uart_tx left idle before any transmit request");
      fail_count++;
    end

  run_on_end_word: assert property (@(posedge sys_clk) disable iff (!rst_n)
    $rose(cpu_run) |-> $past(end_word))
    else begin
      $error("cpu_run rose without a completed end word");
      fail_count++;
    end

endmodule

bind board_top board_chk u_chk (
  .sys_clk(sys_clk), .rst_n(rst_n), .rx_valid(rx_valid), .rx_data(rx_data),
  .mem_req(mem_req), .cpu_run(cpu_run), .tx_start(tx_start), .uart_tx(uart_tx),
  .led_row(led_row)
);

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic sys_clk,
  output logic rst_n
);

  initial begin
    sys_clk = 1'b0;
    forever #50 sys_clk = ~sys_clk;  // 100 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge sys_clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== tb_board.sv ====
`timescale 1ns/1ps

module tb_board;

  localparam int CLKS_PER_BIT = 8;
  localparam int SCAN_PERIOD  = 32;
  localparam int GAP_ON       = 2;
  localparam int GAP_OFF      = 4;
  localparam int LIT_LEN      = SCAN_PERIOD - GAP_ON - GAP_OFF;
  localparam int DARK_LEN     = GAP_ON + GAP_OFF;
  localparam int CYCLE_LIMIT  = 4000;  // ~14 rx bytes, 2 tx bytes, 4 scan frames, margin

  logic                 sys_clk;
  logic                 rst_n;
  logic                 uart_rx;
  logic                 uart_tx;
  board_pkg::mem_req_t  cpu_req;
  board_pkg::cpu_view_t cpu_view;
  board_pkg::word_t     cpu_rd_data;
  logic                 cpu_run;
  logic [7:0]           led_col;
  logic [8:0]           led_row;
  board_pkg::lcd_pins_t lcd;

  int               seed = 36;
  int               errors = 0;
  int               test_errors = 0;
  int               tests = 0;
  int               cycles = 0;
  board_pkg::word_t loaded [3];
  board_pkg::word_t last_rx_word;
  board_pkg::byte_t led_exp;
  board_pkg::byte_t lcd_exp;

  tb_clock u_clk (.sys_clk(sys_clk), .rst_n(rst_n));

  board_top #(
    .CLKS_PER_BIT(CLKS_PER_BIT), .SCAN_PERIOD(SCAN_PERIOD),
    .GAP_ON(GAP_ON), .GAP_OFF(GAP_OFF)
  ) UUT (
    .sys_clk(sys_clk), .rst_n(rst_n), .uart_rx(uart_rx), .uart_tx(uart_tx),
    .cpu_req(cpu_req), .cpu_view(cpu_view), .cpu_rd_data(cpu_rd_data),
    .cpu_run(cpu_run), .led_col(led_col), .led_row(led_row), .lcd(lcd)
  );

  task automatic value_error(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
    test_errors++;
  endtask

  task automatic plain_error(input string msg);
    $display("%0t ns: %s", $time, msg);
    test_errors++;
  endtask

  task automatic end_test(input string name);
    $display("test %0d %s: %0d errors", tests + 1, name, test_errors);
    errors += test_errors;
    test_errors = 0;
    tests++;
  endtask

  // 8N1, lsb first
  task automatic send_byte(input board_pkg::byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge sys_clk);
      uart_rx <= frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge sys_clk);
    end
  endtask

  task automatic send_word(input board_pkg::word_t w);
    send_byte(w[15:8]);  // high byte goes first
    send_byte(w[7:0]);
  endtask

  task automatic receive_tx(output board_pkg::byte_t b, output logic stop_ok);
    @(negedge sys_clk);
    while (uart_tx) @(negedge sys_clk);
    repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);  // middle of start bit
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge sys_clk);
      b[i] = uart_tx;
    end
    repeat (CLKS_PER_BIT) @(negedge sys_clk);
    stop_ok = uart_tx;
  endtask

  task automatic cpu_write(input board_pkg::addr_t a, input logic byt,
                           input board_pkg::word_t data);
    @(posedge sys_clk);
    cpu_req <= '{addr: a, wr: 1'b1, byt: byt, wr_data: data};
    @(posedge sys_clk);
    cpu_req.wr <= 1'b0;
    @(negedge sys_clk);
  endtask

  task automatic check_read(input board_pkg::addr_t a, input board_pkg::word_t exp);
    @(posedge sys_clk);
    cpu_req <= '{addr: a, wr: 1'b0, byt: 1'b0, wr_data: 16'h0000};
    @(posedge sys_clk);
    @(negedge sys_clk);  // data one cycle after the address
    assert (cpu_rd_data == exp)
      else value_error($sformatf("cpu_rd_data @%h", a), cpu_rd_data, exp);
  endtask

  // lcd byte layout: e rw rs - db[3:0]
  function automatic board_pkg::lcd_pins_t lcd_pins(input board_pkg::byte_t v);
    lcd_pins.e  = v[0];
    lcd_pins.rw = v[1];
    lcd_pins.rs = v[2];
    lcd_pins.db = v[7:4];
  endfunction

  task automatic check_lcd_led();
    assert (lcd == lcd_pins(lcd_exp))
      else value_error("lcd", 16'(lcd), 16'(lcd_pins(lcd_exp)));
    assert (UUT.io_led == led_exp)
      else value_error("io_led", 16'(UUT.io_led), 16'(led_exp));
  endtask

  function automatic int lit_row(input logic [8:0] rows);
    lit_row = -1;
    for (int i = 0; i < 9; i++) begin
      if (!rows[i]) lit_row = i;
    end
  endfunction

  // lit and dark run lengths pin each row to the gap window
  task automatic check_scan(input int span);
    int   row;
    int   prev_row;
    int   run_len;
    int   edges;
    int   seen7;
    int   seen2;
    logic lit;
    logic prev_lit;
    prev_row = -1;
    run_len  = 0;
    edges    = 0;
    seen7    = 0;
    seen2    = 0;
    for (int n = 0; n < span; n++) begin
      @(negedge sys_clk);
      row = lit_row(led_row);
      lit = (row >= 0);
      if (n == 0) prev_lit = lit;  // join the scan wherever it is
      if (lit != prev_lit) begin
        if (edges > 0)  // first run is partial
          assert (run_len == (prev_lit ? LIT_LEN : DARK_LEN))
            else plain_error($sformatf("row %s for %0d cycles, outside the gap timing",
                                       prev_lit ? "lit" : "dark", run_len));
        if (lit && prev_row >= 0)
          assert (row == (prev_row + 1) % 9)
            else value_error("led_row index", 16'(row), 16'((prev_row + 1) % 9));
        edges++;
        run_len = 0;
      end
      if (lit) prev_row = row;
      if (row == 7) begin
        seen7++;
        assert (led_col == led_exp) else value_error("led_col row 7", 16'(led_col), 16'(led_exp));
      end
      if (row == 2) begin
        seen2++;
        assert (led_col == cpu_view.stack0[15:8])
          else value_error("led_col row 2", 16'(led_col), 16'(cpu_view.stack0[15:8]));
      end
      run_len++;
      prev_lit = lit;
    end
    assert (seen7 > 0 && seen2 > 0) else plain_error("rows 2 and 7 were never lit");
  endtask

  always @(posedge sys_clk) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    board_pkg::word_t w;
    board_pkg::byte_t b;
    board_pkg::byte_t rx_b;
    board_pkg::addr_t a;
    board_pkg::word_t exp;
    logic             odd;
    logic             stop_ok;
    int               chk_fails;
    uart_rx  = 1'b1;
    cpu_req  = '0;
    cpu_view = '0;
    @(posedge rst_n);
    repeat (2) @(posedge sys_clk);

    for (int i = 0; i < 3; i++) begin
      loaded[i] = 16'($random(seed));
      send_word(loaded[i]);
    end
    repeat (4) @(negedge sys_clk);
    assert (cpu_run == 1'b0) else value_error("cpu_run", 16'(cpu_run), 16'h0);
    send_word(16'hffff);
    while (!cpu_run) @(negedge sys_clk);
    for (int i = 0; i < 3; i++) begin
      check_read(board_pkg::addr_t'(board_pkg::LOAD_BASE + 2 * i), loaded[i]);
    end
    last_rx_word = 16'hffff;
    end_test("load");

    // 0x100..0x1ff stays clear of I/O and the loaded program
    for (int i = 0; i < 4; i++) begin
      a   = board_pkg::addr_t'(10'h100 | ($random(seed) & 10'h0fe));
      w   = 16'($random(seed));
      b   = 8'($random(seed));
      odd = 1'($random(seed));
      cpu_write(a, 1'b0, w);
      check_read(a, w);
      cpu_write({a[9:1], odd}, 1'b1, {8'($random(seed)), b});
      exp = odd ? {b, w[7:0]} : {w[15:8], b};
      check_read(a, exp);
      check_read({a[9:1], 1'b1}, exp);
    end
    end_test("memory");

    w = 16'($random(seed));
    cpu_write(board_pkg::IO_LEDLCD, 1'b0, w);
    led_exp = w[7:0];
    lcd_exp = w[15:8];
    check_lcd_led();
    b = 8'($random(seed));
    cpu_write(board_pkg::IO_LEDLCD, 1'b1, {8'($random(seed)), b});
    led_exp = b;
    check_lcd_led();
    w = 16'($random(seed));
    cpu_write(board_pkg::IO_LCD, 1'b0, w);
    lcd_exp = w[15:8];
    check_lcd_led();
    check_read(board_pkg::IO_LEDLCD, {lcd_exp, led_exp});
    end_test("io");

    for (int i = 0; i < 2; i++) begin
      b = 8'($random(seed));
      cpu_write(board_pkg::IO_UART, 1'b0, {8'($random(seed)), b});
      receive_tx(rx_b, stop_ok);
      assert (rx_b == b) else value_error("uart_tx byte", 16'(rx_b), 16'(b));
      assert (stop_ok) else plain_error("uart_tx stop bit was low");
      repeat (CLKS_PER_BIT) @(negedge sys_clk);  // let the frame finish
    end
    check_read(board_pkg::IO_UART, last_rx_word);
    end_test("uart out");

    @(posedge sys_clk);
    cpu_view <= '{stack0: 16'($random(seed)), stack1: 16'($random(seed)),
                  alu_sel: 6'($random(seed))};
    check_scan(2 * 9 * SCAN_PERIOD);
    end_test("scan");

    send_byte(8'h12);
    while (cpu_run) @(negedge sys_clk);
    w = {8'h12, 8'($random(seed))};
    send_byte(w[7:0]);
    send_word(16'hffff);
    while (!cpu_run) @(negedge sys_clk);
    check_read(board_pkg::LOAD_BASE, w);
    check_read(board_pkg::addr_t'(board_pkg::LOAD_BASE + 2), 16'hffff);  // end word stored too
    end_test("reload");

    chk_fails = UUT.u_chk.fail_count;
    $display("%0d tests, %0d check errors, %0d assertion failures", tests, errors, chk_fails);
    if (errors == 0 && chk_fails == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
board_pkg.sv
uart.sv
program_loader.sv
byte_mem.sv
io_regs.sv
led_matrix_scan.sv
board_top.sv
board_chk.sv
tb_clock.sv
tb_board.sv

// ==== Makefile ====
TOP := tb_board

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf obj_dir
